/* hw/pong_io_defines.svh */
/*
  bridge addresses of the game settings, mclk accumulator constants,
  audio tone level and i2s frame counts
*/
`ifndef PONG_IO_DEFINES_SVH
`define PONG_IO_DEFINES_SVH

//////////////////////////////
// setting register addresses
`define PONG_ADDR_SCORE_STOP    32'h0000_0000
`define PONG_ADDR_COIN_RESET    32'h0000_000C
`define PONG_ADDR_DOUBLE_PADDLE 32'h0000_0014
`define PONG_ADDR_TRAINING      32'h0000_0018

//////////////////////////////
// audio
// mclk toggles at 74.25 MHz * step / wrap, about 24.576 MHz
`define PONG_MCLK_STEP  22'd245760
`define PONG_MCLK_WRAP  22'd742500

// sample sent while the game's sound bit is high
`define PONG_TONE_WORD  32'h7000_7000

// bit periods per channel, of which only the first carry data
`define PONG_I2S_SLOT   32
`define PONG_I2S_ACTIVE 16

`endif

/* hw/pong_bus_pkg.sv */
/*
  bridge bus request type and the game setting register type
*/
package pong_bus_pkg;

  //////////////////////////////
  // bridge bus, synchronous to clk_74a
  // rd and wr are single-cycle strobes, no back-pressure
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  //////////////////////////////
  // game settings written by the host
  typedef struct packed {
    logic score_stop_at_15;
    logic prevent_coin_reset;
    logic double_paddle_height;
    logic training_mode;
  } game_settings_t;

endpackage

/* hw/pong_io_pkg.sv */
/*
  controller key bitmap, player control, video and i2s types
*/
package pong_io_pkg;

  // one controller key word, msb first
  typedef struct packed {
    logic [2:0]  pad_type;
    logic [12:0] rsvd;
    logic        start;
    logic        select;
    logic        r3;
    logic        l3;
    logic        r2;
    logic        l2;
    logic        r1;
    logic        l1;
    logic        face_y;
    logic        face_x;
    logic        face_b;
    logic        face_a;
    logic        right;
    logic        left;
    logic        down;
    logic        up;
  } cont_key_t;

  // controls of a single paddle
  typedef struct packed {
    logic up;
    logic down;
    logic fine;
  } paddle_ctrl_t;

  typedef struct packed {
    paddle_ctrl_t p1;
    paddle_ctrl_t p2;
  } player_ctrl_t;

  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_t;

  typedef struct packed {
    logic mclk;
    logic bclk;
    logic lrck;
    logic dac;
  } i2s_t;

endpackage

/* hw/setting_regs.sv */
/*
  game setting registers on the bridge bus
  write decode, reset values and registered readback
*/
`include "pong_io_defines.svh"

module setting_regs (
  input  logic                        clk_74a,
  input  logic                        arst_n,
  input  pong_bus_pkg::bridge_req_t   bridge,
  output logic [31:0]                 bridge_rd_data,
  output pong_bus_pkg::game_settings_t settings
);

  // coin reset protection is on out of reset
  localparam pong_bus_pkg::game_settings_t SETTINGS_RST = '{
    score_stop_at_15:     1'b0,
    prevent_coin_reset:   1'b1,
    double_paddle_height: 1'b0,
    training_mode:        1'b0
  };

  logic rd_bit;

  // readback mux, unmapped addresses read as zero
  always_comb
  begin
    case (bridge.addr)
      `PONG_ADDR_SCORE_STOP:    rd_bit = settings.score_stop_at_15;
      `PONG_ADDR_COIN_RESET:    rd_bit = settings.prevent_coin_reset;
      `PONG_ADDR_DOUBLE_PADDLE: rd_bit = settings.double_paddle_height;
      `PONG_ADDR_TRAINING:      rd_bit = settings.training_mode;
      default:                  rd_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      settings       <= SETTINGS_RST;
      bridge_rd_data <= 32'd0;
    end
    else
    begin
      if (bridge.wr)
      begin
        case (bridge.addr)
          `PONG_ADDR_SCORE_STOP:    settings.score_stop_at_15     <= bridge.wr_data[0];
          `PONG_ADDR_COIN_RESET:    settings.prevent_coin_reset   <= bridge.wr_data[0];
          `PONG_ADDR_DOUBLE_PADDLE: settings.double_paddle_height <= bridge.wr_data[0];
          `PONG_ADDR_TRAINING:      settings.training_mode        <= bridge.wr_data[0];
          default: ;
        endcase
      end
      // held until the next read
      if (bridge.rd)
        bridge_rd_data <= {31'd0, rd_bit};
    end
  end

endmodule

/* hw/controller_decode.sv */
/*
  controller key synchronizers, player control mapping
  and the coin pulse from the start key
*/
module controller_decode (
  input  logic                      clk_74a,
  input  logic                      arst_n,
  input  pong_io_pkg::cont_key_t    cont1_key,
  input  pong_io_pkg::cont_key_t    cont2_key,
  output pong_io_pkg::player_ctrl_t player_ctrl,
  output logic                      coin_insert
);

  pong_io_pkg::cont_key_t cont1_meta;
  pong_io_pkg::cont_key_t cont1_sync;
  pong_io_pkg::cont_key_t cont2_meta;
  pong_io_pkg::cont_key_t cont2_sync;
  logic                   start_prev;
  logic                   share_p2;

  //////////////////////////////
  // two-stage synchronizers
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cont1_meta <= '0;
      cont1_sync <= '0;
      cont2_meta <= '0;
      cont2_sync <= '0;
    end
    else
    begin
      cont1_meta <= cont1_key;
      cont1_sync <= cont1_meta;
      cont2_meta <= cont2_key;
      cont2_sync <= cont2_meta;
    end
  end

  //////////////////////////////
  // player mapping
  // a plain pad on port 1 (pad type 0) can also steer player 2
  assign share_p2 = (cont1_sync.pad_type == 3'b000);

  assign player_ctrl.p1.up   = cont1_sync.up;
  assign player_ctrl.p1.down = cont1_sync.down;
  assign player_ctrl.p1.fine = cont1_sync.l1;

  assign player_ctrl.p2.up   = cont2_sync.up   | (share_p2 & cont1_sync.face_x);
  assign player_ctrl.p2.down = cont2_sync.down | (share_p2 & cont1_sync.face_b);
  assign player_ctrl.p2.fine = cont2_sync.l1   | (share_p2 & cont1_sync.r1);

  //////////////////////////////
  // coin pulse, one cycle per press so holding start does not repeat
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      start_prev  <= 1'b0;
      coin_insert <= 1'b0;
    end
    else
    begin
      start_prev  <= cont1_sync.start;
      coin_insert <= cont1_sync.start & ~start_prev;
    end
  end

endmodule

/* hw/video_cleanup.sv */
/*
  video output conditioning for the scaler
  rgb blanked outside de, syncs cut to single-cycle pulses
*/
module video_cleanup (
  input  logic                clk_74a,
  input  logic                arst_n,
  input  pong_io_pkg::video_t game_video,
  output pong_io_pkg::video_t video
);

  logic hs_prev;
  logic vs_prev;

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      video   <= '0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end
    else
    begin
      video.de  <= game_video.de;
      // scaler expects black outside the active window
      video.rgb <= game_video.de ? game_video.rgb : 24'd0;

      // pulse on the rising edge of each sync level
      video.hs <= game_video.hs & ~hs_prev;
      video.vs <= game_video.vs & ~vs_prev;
      hs_prev  <= game_video.hs;
      vs_prev  <= game_video.vs;
    end
  end

endmodule

/* hw/audio_i2s_out.sv */
/*
  i2s output of the game sound
  fractional mclk accumulator, bclk divider and the sample serializer
*/
`include "pong_io_defines.svh"

module audio_i2s_out (
  input  logic              clk_74a,
  input  logic              arst_n,
  input  logic              sound,
  output pong_io_pkg::i2s_t i2s
);

  localparam logic [4:0] SLOT_LAST  = 5'(`PONG_I2S_SLOT - 1);
  localparam logic [4:0] ACTIVE_CNT = 5'(`PONG_I2S_ACTIVE);

  logic [21:0] mclk_acc;
  logic        mclk_hit;
  logic        mclk_rise;
  logic        mclk;
  logic [1:0]  mclk_div;
  logic        bclk_prev;
  logic        bclk_fall;
  logic [4:0]  slot_cnt;
  logic [31:0] shifter;
  logic        lrck;
  logic        dac;

  //////////////////////////////
  // mclk and bclk strobes
  assign mclk_hit  = (mclk_acc >= `PONG_MCLK_WRAP);
  assign mclk_rise = mclk_hit & ~mclk;
  // bclk is the msb of the mclk divider
  assign bclk_fall = bclk_prev & ~mclk_div[1];

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mclk_acc  <= 22'd0;
      mclk      <= 1'b0;
      mclk_div  <= 2'd0;
      bclk_prev <= 1'b0;
    end
    else
    begin
      mclk_acc  <= mclk_hit ? mclk_acc - `PONG_MCLK_WRAP + `PONG_MCLK_STEP
                            : mclk_acc + `PONG_MCLK_STEP;
      if (mclk_hit)
        mclk <= ~mclk;
      if (mclk_rise)
        mclk_div <= mclk_div + 2'd1;
      bclk_prev <= mclk_div[1];
    end
  end

  //////////////////////////////
  // serializer, steps once per bclk falling edge
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot_cnt <= 5'd0;
      lrck     <= 1'b0;
      dac      <= 1'b0;
      shifter  <= 32'd0;
    end
    else if (bclk_fall)
    begin
      dac      <= shifter[31];
      slot_cnt <= slot_cnt + 5'd1;
      if (slot_cnt == SLOT_LAST)
      begin
        lrck <= ~lrck;
        // new sample at the start of each left/right pair
        if (!lrck)
          shifter <= sound ? `PONG_TONE_WORD : 32'd0;
      end
      else if (slot_cnt < ACTIVE_CNT)
      begin
        shifter <= {shifter[30:0], 1'b0};
      end
    end
  end

  assign i2s.mclk = mclk;
  assign i2s.bclk = mclk_div[1];
  assign i2s.lrck = lrck;
  assign i2s.dac  = dac;

endmodule

/* hw/pong_io_shell.sv */
/*
  top level of the paddle-game i/o shell
  settings, controller decode, video cleanup and i2s audio
*/
module pong_io_shell (
  input  logic                         clk_74a,
  input  logic                         arst_n,
  input  pong_bus_pkg::bridge_req_t    bridge,
  output logic [31:0]                  bridge_rd_data,
  output pong_bus_pkg::game_settings_t settings,
  input  pong_io_pkg::cont_key_t       cont1_key,
  input  pong_io_pkg::cont_key_t       cont2_key,
  output pong_io_pkg::player_ctrl_t    player_ctrl,
  output logic                         coin_insert,
  input  pong_io_pkg::video_t          game_video,
  output pong_io_pkg::video_t          video,
  input  logic                         sound,
  output pong_io_pkg::i2s_t            i2s
);

  //////////////////////////////
  // host side
  setting_regs setting_regs_i (
    .clk_74a        (clk_74a),
    .arst_n         (arst_n),
    .bridge         (bridge),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings)
  );

  //////////////////////////////
  // player inputs
  controller_decode controller_decode_i (
    .clk_74a     (clk_74a),
    .arst_n      (arst_n),
    .cont1_key   (cont1_key),
    .cont2_key   (cont2_key),
    .player_ctrl (player_ctrl),
    .coin_insert (coin_insert)
  );

  //////////////////////////////
  // outputs to scaler and dac
  video_cleanup video_cleanup_i (
    .clk_74a    (clk_74a),
    .arst_n     (arst_n),
    .game_video (game_video),
    .video      (video)
  );

  audio_i2s_out audio_i2s_out_i (
    .clk_74a (clk_74a),
    .arst_n  (arst_n),
    .sound   (sound),
    .i2s     (i2s)
  );

endmodule

/* tb/pong_io_shell_sva.sv */
/*
  concurrent assertions on the i/o shell outputs
  coin and hsync pulse width, rgb blanking, lrck timing
*/
module pong_io_shell_sva (
  input logic                clk_74a,
  input logic                arst_n,
  input logic                coin_insert,
  input pong_io_pkg::video_t video,
  input pong_io_pkg::i2s_t   i2s
);

  timeunit 1ns;
  timeprecision 1ps;

  // single-cycle pulses
  coin_single: assert property (@(posedge clk_74a) disable iff (!arst_n)
    coin_insert |=> !coin_insert)
    else $error("coin_insert stayed high for two cycles");

  hs_single: assert property (@(posedge clk_74a) disable iff (!arst_n)
    video.hs |=> !video.hs)
    else $error("video hs stayed high for two cycles");

  rgb_blank: assert property (@(posedge clk_74a) disable iff (!arst_n)
    !video.de |-> (video.rgb == 24'd0))
    else $error("video rgb not zero outside data enable");

  // serializer steps one cycle after bclk goes low
  lrck_timing: assert property (@(posedge clk_74a) disable iff (!arst_n)
    (i2s.lrck != $past(i2s.lrck)) |-> ($past(i2s.bclk, 2) && !$past(i2s.bclk)))
    else $error("lrck changed outside the cycle after a bclk fall");

endmodule

bind pong_io_shell pong_io_shell_sva pong_io_shell_sva_i (
  .clk_74a     (clk_74a),
  .arst_n      (arst_n),
  .coin_insert (coin_insert),
  .video       (video),
  .i2s         (i2s)
);

/* tb/pong_io_shell_tb.sv */
/*
  testbench of the paddle-game i/o shell
  directed tests of settings, controllers, video and i2s audio
*/
`include "pong_io_defines.svh"

module pong_io_shell_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // audio needs up to 5 half frames of ~775 cycles plus the mclk window
  // the other tests need a few hundred cycles
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MCLK_WINDOW    = 7425;
  // window * step / wrap
  localparam int MCLK_TOGGLES   = 2457;
  // a quarter of the mclk toggles
  localparam int BCLK_TOGGLES   = 614;

  logic                         clk_74a = 1'b0;
  logic                         arst_n;
  pong_bus_pkg::bridge_req_t    bridge;
  logic [31:0]                  bridge_rd_data;
  pong_bus_pkg::game_settings_t settings;
  pong_io_pkg::cont_key_t       cont1_key;
  pong_io_pkg::cont_key_t       cont2_key;
  pong_io_pkg::player_ctrl_t    player_ctrl;
  logic                         coin_insert;
  pong_io_pkg::video_t          game_video;
  pong_io_pkg::video_t          video;
  logic                         sound;
  pong_io_pkg::i2s_t            i2s;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rng_state = 32'd78;
  logic        exp_set [4];

  pong_io_shell pong_io_shell_i (
    .clk_74a        (clk_74a),
    .arst_n         (arst_n),
    .bridge         (bridge),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .player_ctrl    (player_ctrl),
    .coin_insert    (coin_insert),
    .game_video     (game_video),
    .video          (video),
    .sound          (sound),
    .i2s            (i2s)
  );

  always #4 clk_74a = ~clk_74a;

  always @(posedge clk_74a)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run still busy after %0d cycles, %0d errors so far", cycles, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge <= {addr, 1'b0, 1'b1, data};
    @(posedge clk_74a);
    bridge <= '0;
  endtask

  // readback is valid one cycle after the rd strobe
  task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] expected);
    @(posedge clk_74a);
    bridge <= {addr, 1'b1, 1'b0, 32'd0};
    @(posedge clk_74a);
    bridge <= '0;
    @(negedge clk_74a);
    check_value(bridge_rd_data, expected, $sformatf("readback at address %h", addr));
  endtask

  task automatic wait_lrck_rise();
    logic prev;
    @(negedge clk_74a);
    prev = i2s.lrck;
    @(negedge clk_74a);
    while (prev || !i2s.lrck)
    begin
      prev = i2s.lrck;
      @(negedge clk_74a);
    end
  endtask

  task automatic wait_bclk_fall();
    logic prev;
    prev = i2s.bclk;
    @(negedge clk_74a);
    while (!prev || i2s.bclk)
    begin
      prev = i2s.bclk;
      @(negedge clk_74a);
    end
  endtask

  // 32 dac bits, msb first
  task automatic collect_dac(output logic [31:0] frame);
    int i;
    frame = '0;
    for (i = 0; i < 32; i++)
    begin
      wait_bclk_fall();
      // dac steps one cycle after bclk falls
      @(negedge clk_74a);
      frame = {frame[30:0], i2s.dac};
    end
  endtask

  //////////////////////////////
  // tests
  task automatic test_settings();
    logic [31:0] addr_list [4];
    logic [31:0] data;
    int          i;
    addr_list[0] = `PONG_ADDR_SCORE_STOP;
    addr_list[1] = `PONG_ADDR_COIN_RESET;
    addr_list[2] = `PONG_ADDR_DOUBLE_PADDLE;
    addr_list[3] = `PONG_ADDR_TRAINING;
    // only coin reset protection is on after reset
    exp_set[0] = 1'b0;
    exp_set[1] = 1'b1;
    exp_set[2] = 1'b0;
    exp_set[3] = 1'b0;
    for (i = 0; i < 4; i++)
      bus_read_check(addr_list[i], {31'd0, exp_set[i]});
    for (i = 0; i < 16; i++)
    begin
      data = next_random();
      bus_write(addr_list[i % 4], data);
      exp_set[i % 4] = data[0];
      bus_read_check(addr_list[i % 4], {31'd0, exp_set[i % 4]});
    end
    check_value({28'd0, settings}, {28'd0, exp_set[0], exp_set[1], exp_set[2], exp_set[3]},
                "settings outputs");
    // all ones so that a write or read that aliases an unmapped address shows up
    for (i = 0; i < 4; i++)
    begin
      exp_set[i] = 1'b1;
      bus_write(addr_list[i], 32'd1);
    end
    // unmapped addresses
    bus_write(32'h0000_0004, 32'd0);
    bus_write(32'h0000_001C, 32'd0);
    for (i = 0; i < 4; i++)
      bus_read_check(addr_list[i], {31'd0, exp_set[i]});
    bus_read_check(32'h0000_0004, 32'd0);
    bus_read_check(32'h0000_001C, 32'd0);
  endtask

  task automatic test_player_map();
    logic [31:0] k1;
    logic [31:0] k2;
    logic        share;
    logic [5:0]  expected;
    logic [5:0]  prev_expected;
    int          i;
    // keys are still zero from the start
    prev_expected = '0;
    for (i = 0; i < 24; i++)
    begin
      k1 = next_random();
      k2 = next_random();
      // alternate a plain pad and other pad types on port 1
      if (i % 2 == 0)
        k1[31:29] = 3'b000;
      else if (k1[31:29] == 3'b000)
        k1[31:29] = 3'b101;
      @(posedge clk_74a);
      cont1_key <= k1;
      cont2_key <= k2;
      // old mapping one cycle after the change
      @(posedge clk_74a);
      @(negedge clk_74a);
      check_value({26'd0, player_ctrl}, {26'd0, prev_expected}, "player mapping too early");
      @(posedge clk_74a);
      @(negedge clk_74a);
      share = (k1[31:29] == 3'b000);
      expected = {k1[0], k1[1], k1[8],
                  k2[0] | (share & k1[6]), k2[1] | (share & k1[5]), k2[8] | (share & k1[9])};
      check_value({26'd0, player_ctrl}, {26'd0, expected}, "player mapping");
      prev_expected = expected;
    end
  endtask

  task automatic test_coin();
    int pulses;
    int i;
    pulses = 0;
    @(posedge clk_74a);
    cont1_key <= '0;
    cont2_key <= '0;
    repeat (4) @(posedge clk_74a);
    // start key pressed for 10 cycles
    cont1_key <= 32'h0000_8000;
    for (i = 1; i <= 16; i++)
    begin
      @(posedge clk_74a);
      if (i == 10)
        cont1_key <= '0;
      @(negedge clk_74a);
      check_value({31'd0, coin_insert}, {31'd0, i == 3},
                  $sformatf("coin_insert %0d cycles after start press", i));
      if (coin_insert)
        pulses++;
    end
    check_value(pulses, 32'd1, "number of coin pulses");
  endtask

  task automatic test_video();
    logic [31:0] r;
    logic        de;
    int          i;
    for (i = 0; i < 32; i++)
    begin
      r = next_random();
      de = i[0];
      @(posedge clk_74a);
      game_video <= {de, 1'b0, 1'b0, r[23:0]};
      @(posedge clk_74a);
      @(negedge clk_74a);
      check_value({31'd0, video.de}, {31'd0, de}, "video de");
      check_value({8'd0, video.rgb}, {8'd0, de ? r[23:0] : 24'd0}, "video rgb");
    end
    // syncs held high for 5 cycles
    @(posedge clk_74a);
    game_video <= {1'b0, 1'b1, 1'b1, 24'd0};
    for (i = 1; i <= 8; i++)
    begin
      @(posedge clk_74a);
      if (i == 5)
        game_video <= '0;
      @(negedge clk_74a);
      check_value({31'd0, video.hs}, {31'd0, i == 1}, $sformatf("hs pulse, cycle %0d", i));
      check_value({31'd0, video.vs}, {31'd0, i == 1}, $sformatf("vs pulse, cycle %0d", i));
    end
  endtask

  task automatic test_audio();
    logic [31:0] frame;
    logic        prev;
    logic        bprev;
    logic        in_range;
    int          toggles;
    int          btoggles;
    int          i;
    @(posedge clk_74a);
    sound <= 1'b1;
    wait_lrck_rise();
    collect_dac(frame);
    // left channel carries the upper tone half
    check_value(frame, `PONG_TONE_WORD & 32'hFFFF_0000, "dac frame with sound high");
    @(posedge clk_74a);
    sound <= 1'b0;
    wait_lrck_rise();
    collect_dac(frame);
    check_value(frame, 32'd0, "dac frame with sound low");

    toggles  = 0;
    btoggles = 0;
    @(negedge clk_74a);
    prev  = i2s.mclk;
    bprev = i2s.bclk;
    for (i = 0; i < MCLK_WINDOW; i++)
    begin
      @(negedge clk_74a);
      if (i2s.mclk != prev)
        toggles++;
      if (i2s.bclk != bprev)
        btoggles++;
      prev  = i2s.mclk;
      bprev = i2s.bclk;
    end
    in_range = (toggles >= MCLK_TOGGLES - 1) && (toggles <= MCLK_TOGGLES + 1);
    check_value({31'd0, in_range}, 32'd1,
                $sformatf("mclk toggled %0d times in %0d cycles", toggles, MCLK_WINDOW));
    in_range = (btoggles >= BCLK_TOGGLES - 1) && (btoggles <= BCLK_TOGGLES + 1);
    check_value({31'd0, in_range}, 32'd1,
                $sformatf("bclk toggled %0d times in %0d cycles", btoggles, MCLK_WINDOW));
  endtask

  //////////////////////////////
  // main sequence
  initial
  begin
    arst_n     = 1'b0;
    bridge     = '0;
    cont1_key  = '0;
    cont2_key  = '0;
    game_video = '0;
    sound      = 1'b0;
    repeat (2) @(posedge clk_74a);
    arst_n <= 1'b1;

    test_settings();
    test_player_map();
    test_coin();
    test_video();
    test_audio();

    $display("Summary: %0d errors after %0d cycles", errors, cycles);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/pong_bus_pkg.sv
hw/pong_io_pkg.sv
hw/setting_regs.sv
hw/controller_decode.sv
hw/video_cleanup.sv
hw/audio_i2s_out.sv
hw/pong_io_shell.sv
tb/pong_io_shell_sva.sv
tb/pong_io_shell_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the i/o shell testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module pong_io_shell_tb -f filelist.f

sim_out=$(./obj_dir/Vpong_io_shell_tb 2>&1) || true
echo "$sim_out"

if grep -q "All tests passed" <<< "$sim_out"
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
